// ==== src/sb_config.svh ====
////////////////////////////////////////
// Address map and sizing of the PWM subsystem
// Included by the packages and by RTL that needs ranges or widths
////////////////////////////////////////

`ifndef SB_CONFIG_SVH
`define SB_CONFIG_SVH

// Simplebus word widths
`define SB_ADDR_W 32
`define SB_DATA_W 32

// Byte ranges with inclusive low and exclusive high bound
`define RAM_LOW  32'h0000_0000
`define RAM_HIGH 32'h0000_0100
`define PWM_LOW  32'h0000_1000
`define PWM_HIGH 32'h0000_1010

// Scratch RAM depth in bus words
`define RAM_WORDS 64

// Width of the PWM counter, period and duty
`define PWM_CNT_W 16

`endif

// ==== src/bus_pkg.sv ====
////////////////////////////////////////
// Simplebus word types
// Imported by the interconnect, the slaves and the testbench
////////////////////////////////////////

`default_nettype none

`include "sb_config.svh"

package bus_pkg;

        // Byte address as seen on the bus
        typedef logic [`SB_ADDR_W-1:0] sb_addr_t;

        // Read and write data word
        typedef logic [`SB_DATA_W-1:0] sb_data_t;

endpackage

`default_nettype wire

// ==== src/pwm_pkg.sv ====
////////////////////////////////////////
// PWM register map and counter types
// Shared by the register block, the PWM core and the testbench
////////////////////////////////////////

`default_nettype none

`include "sb_config.svh"

package pwm_pkg;

        // Byte offsets inside the PWM window
        typedef enum logic [3:0] {
                CTRL   = 4'h0,
                PERIOD = 4'h4,
                DUTY   = 4'h8
        } pwm_reg_offset_t;

        // Enable flag position in CTRL
        localparam int CTRL_ENABLE_BIT = 0;

        // Counter, period and duty value
        typedef logic [`PWM_CNT_W-1:0] pwm_count_t;

endpackage

`default_nettype wire

// ==== src/sb_interconnect.sv ====
////////////////////////////////////////
// Registered Simplebus address decoder
// One master port fanned out to the RAM and PWM windows,
// responses merged and registered on the way back
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "sb_config.svh"

module sb_interconnect (
        input wire clock,
        input wire rst,
        input wire bus_pkg::sb_addr_t m_address,
        input wire m_write_strobe,
        input wire m_read_strobe,
        input wire bus_pkg::sb_data_t m_write_data,
        output bus_pkg::sb_data_t m_read_data,
        output logic m_ready,
        output bus_pkg::sb_addr_t ram_address,
        output logic ram_write_strobe,
        output logic ram_read_strobe,
        output bus_pkg::sb_data_t ram_write_data,
        input wire bus_pkg::sb_data_t ram_read_data,
        input wire ram_ready,
        output bus_pkg::sb_addr_t pwm_address,
        output logic pwm_write_strobe,
        output logic pwm_read_strobe,
        output bus_pkg::sb_data_t pwm_write_data,
        input wire bus_pkg::sb_data_t pwm_read_data,
        input wire pwm_ready
);
        import bus_pkg::*;

        logic ram_sel;
        logic pwm_sel;

        function automatic logic in_range(sb_addr_t addr, sb_addr_t low, sb_addr_t high);
                return (addr >= low) && (addr < high);
        endfunction

        assign ram_sel = in_range(m_address, `RAM_LOW, `RAM_HIGH);
        assign pwm_sel = in_range(m_address, `PWM_LOW, `PWM_HIGH);

        // Request payload, zero toward slaves that are not addressed
        always_ff @(posedge clock) begin
                ram_address <= ram_sel ? m_address : '0;
                ram_write_data <= ram_sel ? m_write_data : '0;
                pwm_address <= pwm_sel ? m_address : '0;
                pwm_write_data <= pwm_sel ? m_write_data : '0;
        end

        always_ff @(posedge clock) begin
                if (rst) begin
                        ram_write_strobe <= 1'b0;
                        ram_read_strobe <= 1'b0;
                        pwm_write_strobe <= 1'b0;
                        pwm_read_strobe <= 1'b0;
                        m_read_data <= '0;
                        m_ready <= 1'b0;
                end else begin
                        ram_write_strobe <= ram_sel & m_write_strobe;
                        ram_read_strobe <= ram_sel & m_read_strobe;
                        pwm_write_strobe <= pwm_sel & m_write_strobe;
                        pwm_read_strobe <= pwm_sel & m_read_strobe;
                        // Idle slaves return zero so an OR merges cleanly
                        m_read_data <= ram_read_data | pwm_read_data;
                        m_ready <= ram_ready & pwm_ready;
                end
        end

        // Protocol checks
        master_single_strobe: assert property (
                @(posedge clock) disable iff (rst)
                !(m_write_strobe && m_read_strobe)
        );

        slave_single_strobe: assert property (
                @(posedge clock) disable iff (rst)
                $onehot0({ram_write_strobe, ram_read_strobe,
                          pwm_write_strobe, pwm_read_strobe})
        );

endmodule

`default_nettype wire

// ==== src/sb_ram.sv ====
////////////////////////////////////////
// Single-port scratch RAM on Simplebus
// Writes land one cycle after the strobe, reads return a cycle later
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "sb_config.svh"

module sb_ram (
        input wire clock,
        input wire rst,
        input wire bus_pkg::sb_addr_t address,
        input wire write_strobe,
        input wire read_strobe,
        input wire bus_pkg::sb_data_t write_data,
        output bus_pkg::sb_data_t read_data,
        output logic ready
);
        import bus_pkg::*;

        localparam int INDEX_W = $clog2(`RAM_WORDS);

        sb_data_t mem [`RAM_WORDS];
        sb_addr_t offset;
        logic [INDEX_W-1:0] index;

        // Word index inside the RAM window
        assign offset = address - `RAM_LOW;
        assign index = offset[INDEX_W+1:2];

        always_ff @(posedge clock) begin
                if (write_strobe) begin
                        mem[index] <= write_data;
                end
        end

        // Read data is held for one cycle only and is zero otherwise
        always_ff @(posedge clock) begin
                if (rst) begin
                        read_data <= '0;
                        ready <= 1'b0;
                end else begin
                        ready <= 1'b1;
                        if (read_strobe) begin
                                read_data <= mem[index];
                        end else begin
                                read_data <= '0;
                        end
                end
        end

endmodule

`default_nettype wire

// ==== src/pwm_regs.sv ====
////////////////////////////////////////
// PWM control registers on Simplebus
// Holds enable, period and duty and drives them to the PWM core
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "sb_config.svh"

module pwm_regs (
        input wire clock,
        input wire rst,
        input wire bus_pkg::sb_addr_t address,
        input wire write_strobe,
        input wire read_strobe,
        input wire bus_pkg::sb_data_t write_data,
        output bus_pkg::sb_data_t read_data,
        output logic ready,
        output logic enable,
        output pwm_pkg::pwm_count_t period,
        output pwm_pkg::pwm_count_t duty
);
        import bus_pkg::*;
        import pwm_pkg::*;

        sb_addr_t offset;
        logic [$bits(pwm_reg_offset_t)-1:0] reg_offset;

        // Register offset inside the PWM window
        assign offset = address - `PWM_LOW;
        assign reg_offset = offset[$bits(pwm_reg_offset_t)-1:0];

        always_ff @(posedge clock) begin
                if (rst) begin
                        enable <= 1'b0;
                        period <= '0;
                        duty <= '0;
                end else if (write_strobe) begin
                        case (reg_offset)
                                CTRL: enable <= write_data[CTRL_ENABLE_BIT];
                                PERIOD: period <= write_data[`PWM_CNT_W-1:0];
                                DUTY: duty <= write_data[`PWM_CNT_W-1:0];
                                // Writes to unknown offsets are dropped
                                default: ;
                        endcase
                end
        end

        always_ff @(posedge clock) begin
                if (rst) begin
                        read_data <= '0;
                        ready <= 1'b0;
                end else begin
                        ready <= 1'b1;
                        if (read_strobe) begin
                                case (reg_offset)
                                        CTRL: read_data <= sb_data_t'(enable) << CTRL_ENABLE_BIT;
                                        PERIOD: read_data <= sb_data_t'(period);
                                        DUTY: read_data <= sb_data_t'(duty);
                                        default: read_data <= '0;
                                endcase
                        end else begin
                                read_data <= '0;
                        end
                end
        end

endmodule

`default_nettype wire

// ==== src/pwm_core.sv ====
////////////////////////////////////////
// PWM counter and output stage
// Period and duty are sampled at each wrap of the counter
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module pwm_core (
        input wire clock,
        input wire rst,
        input wire enable,
        input wire pwm_pkg::pwm_count_t period,
        input wire pwm_pkg::pwm_count_t duty,
        output logic pwm_out
);
        import pwm_pkg::*;

        pwm_count_t count;
        pwm_count_t period_shadow;
        pwm_count_t duty_shadow;
        logic [$bits(pwm_count_t):0] count_next;
        logic wrap;
        logic high;

        assign count_next = {1'b0, count} + 1'b1;
        // Last count of the period, every cycle for a zero period
        assign wrap = count_next >= {1'b0, period_shadow};
        // Duty clipped at period so a zero period stays low
        assign high = (count < duty_shadow) && (count < period_shadow);

        always_ff @(posedge clock) begin
                if (rst) begin
                        count <= '0;
                        period_shadow <= '0;
                        duty_shadow <= '0;
                        pwm_out <= 1'b0;
                end else if (!enable) begin
                        // Shadows track the registers while stopped
                        count <= '0;
                        period_shadow <= period;
                        duty_shadow <= duty;
                        pwm_out <= 1'b0;
                end else begin
                        pwm_out <= high;
                        if (wrap) begin
                                count <= '0;
                                period_shadow <= period;
                                duty_shadow <= duty;
                        end else begin
                                count <= count_next[$bits(pwm_count_t)-1:0];
                        end
                end
        end

        disable_forces_low: assert property (
                @(posedge clock) disable iff (rst)
                !$past(enable) |-> !pwm_out
        );

endmodule

`default_nettype wire

// ==== src/pwm_subsystem.sv ====
////////////////////////////////////////
// PWM subsystem top level
// Simplebus master port in front of a scratch RAM and a PWM channel
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module pwm_subsystem (
        input wire clock,
        input wire rst,
        input wire bus_pkg::sb_addr_t address,
        input wire write_strobe,
        input wire read_strobe,
        input wire bus_pkg::sb_data_t write_data,
        output bus_pkg::sb_data_t read_data,
        output logic ready,
        output logic pwm_out
);
        import bus_pkg::*;
        import pwm_pkg::*;

        // RAM side of the interconnect
        sb_addr_t ram_address;
        logic ram_write_strobe;
        logic ram_read_strobe;
        sb_data_t ram_write_data;
        sb_data_t ram_read_data;
        logic ram_ready;

        // PWM register side of the interconnect
        sb_addr_t pwm_address;
        logic pwm_write_strobe;
        logic pwm_read_strobe;
        sb_data_t pwm_write_data;
        sb_data_t pwm_read_data;
        logic pwm_ready;

        // Register block to core
        logic pwm_enable;
        pwm_count_t pwm_period;
        pwm_count_t pwm_duty;

        sb_interconnect i_interconnect (
                .clock(clock),
                .rst(rst),
                .m_address(address),
                .m_write_strobe(write_strobe),
                .m_read_strobe(read_strobe),
                .m_write_data(write_data),
                .m_read_data(read_data),
                .m_ready(ready),
                .ram_address(ram_address),
                .ram_write_strobe(ram_write_strobe),
                .ram_read_strobe(ram_read_strobe),
                .ram_write_data(ram_write_data),
                .ram_read_data(ram_read_data),
                .ram_ready(ram_ready),
                .pwm_address(pwm_address),
                .pwm_write_strobe(pwm_write_strobe),
                .pwm_read_strobe(pwm_read_strobe),
                .pwm_write_data(pwm_write_data),
                .pwm_read_data(pwm_read_data),
                .pwm_ready(pwm_ready)
        );

        sb_ram i_ram (
                .clock(clock),
                .rst(rst),
                .address(ram_address),
                .write_strobe(ram_write_strobe),
                .read_strobe(ram_read_strobe),
                .write_data(ram_write_data),
                .read_data(ram_read_data),
                .ready(ram_ready)
        );

        pwm_regs i_pwm_regs (
                .clock(clock),
                .rst(rst),
                .address(pwm_address),
                .write_strobe(pwm_write_strobe),
                .read_strobe(pwm_read_strobe),
                .write_data(pwm_write_data),
                .read_data(pwm_read_data),
                .ready(pwm_ready),
                .enable(pwm_enable),
                .period(pwm_period),
                .duty(pwm_duty)
        );

        pwm_core i_pwm_core (
                .clock(clock),
                .rst(rst),
                .enable(pwm_enable),
                .period(pwm_period),
                .duty(pwm_duty),
                .pwm_out(pwm_out)
        );

endmodule

`default_nettype wire

// ==== bench/pwm_subsystem_tb.sv ====
////////////////////////////////////////
// Self-checking testbench for the PWM subsystem
// Replays bus operations and PWM measurements
// from the case file in the bench folder
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "sb_config.svh"

module pwm_subsystem_tb;
        import bus_pkg::*;
        import pwm_pkg::*;

        localparam int READY_TIMEOUT = 20;

        logic clock;
        logic rst;
        sb_addr_t address;
        logic write_strobe;
        logic read_strobe;
        sb_data_t write_data;
        sb_data_t read_data;
        logic ready;
        logic pwm_out;

        pwm_subsystem i_dut (
                .clock(clock),
                .rst(rst),
                .address(address),
                .write_strobe(write_strobe),
                .read_strobe(read_strobe),
                .write_data(write_data),
                .read_data(read_data),
                .ready(ready),
                .pwm_out(pwm_out)
        );

        initial begin
                clock = 1'b0;
                forever begin
                        #10 clock = ~clock;
                end
        end

        task automatic report_failure(input string message);
                $display("%s", message);
                $display("test failed");
                $fatal(1, "simulation stopped at the first failure");
        endtask

        task automatic check_data(input sb_data_t actual, input sb_data_t expected,
                        input string what);
                if (actual !== expected) begin
                        report_failure($sformatf("error at %0d ns: %s is %h, expected %h",
                                $time, what, actual, expected));
                end
        endtask

        task automatic check_high_count(input pwm_count_t actual, input pwm_count_t expected,
                        input string what);
                if (actual !== expected) begin
                        report_failure($sformatf("error at %0d ns: %s is %0d, expected %0d",
                                $time, what, actual, expected));
                end
        endtask

        // A case line must carry every value its kind needs
        task automatic require_fields(input int got, input int needed);
                if (got != needed) begin
                        report_failure("a line of the case file has missing values");
                end
        endtask

        task automatic wait_ready();
                int cycles;
                cycles = 0;
                @(negedge clock);
                while (ready !== 1'b1) begin
                        cycles++;
                        if (cycles > READY_TIMEOUT) begin
                                report_failure("ready did not go high within the timeout");
                        end
                        @(negedge clock);
                end
        endtask

        task automatic bus_write(input sb_addr_t addr, input sb_data_t data);
                wait_ready();
                @(posedge clock);
                address <= addr;
                write_data <= data;
                write_strobe <= 1'b1;
                @(posedge clock);
                address <= '0;
                write_data <= '0;
                write_strobe <= 1'b0;
        endtask

        // Data must show up in the third cycle after the strobe and only there
        task automatic bus_read(input sb_addr_t addr, output sb_data_t data);
                wait_ready();
                @(posedge clock);
                address <= addr;
                read_strobe <= 1'b1;
                @(posedge clock);
                address <= '0;
                read_strobe <= 1'b0;
                for (int cycle = 1; cycle <= 4; cycle++) begin
                        @(negedge clock);
                        if (cycle == 3) begin
                                data = read_data;
                        end else begin
                                check_data(read_data, '0, "read data outside cycle 3");
                        end
                end
        endtask

        // Returns at the negedge of the first cycle of a period
        task automatic find_period_start(input pwm_count_t period, input pwm_count_t expected);
                int cycles;
                logic previous;
                logic steady;
                logic found;
                // A constant output has no edge, so its level marks the start
                steady = (expected == 0) || (expected >= period);
                cycles = 0;
                found = 1'b0;
                @(negedge clock);
                previous = pwm_out;
                while (!found) begin
                        @(negedge clock);
                        cycles++;
                        if (steady) begin
                                found = (pwm_out === (expected != 0));
                        end else begin
                                found = (previous === 1'b0) && (pwm_out === 1'b1);
                        end
                        previous = pwm_out;
                        if (!found && cycles > 4 * period + 16) begin
                                report_failure("no PWM period start seen within the timeout");
                        end
                end
        endtask

        // Optionally rewrites duty early in the measured period
        task automatic measure_period(input pwm_count_t period, input pwm_count_t expected,
                        input logic change, input pwm_count_t new_duty);
                pwm_count_t highs;
                find_period_start(period, expected);
                highs = (pwm_out === 1'b1) ? 1 : 0;
                for (int i = 1; i < period; i++) begin
                        @(posedge clock);
                        if (change && i == 1) begin
                                address <= sb_addr_t'(`PWM_LOW + DUTY);
                                write_data <= sb_data_t'(new_duty);
                                write_strobe <= 1'b1;
                        end else if (change && i == 2) begin
                                address <= '0;
                                write_data <= '0;
                                write_strobe <= 1'b0;
                        end
                        @(negedge clock);
                        if (pwm_out === 1'b1) begin
                                highs++;
                        end
                end
                check_high_count(highs, expected, "pwm_out high cycles in one period");
        endtask

        task automatic fill_ram(input sb_addr_t first, input int words);
                sb_data_t expected_words[$];
                sb_data_t value;
                for (int i = 0; i < words; i++) begin
                        expected_words.push_back($urandom());
                        bus_write(first + sb_addr_t'(4 * i), expected_words[i]);
                end
                for (int i = 0; i < words; i++) begin
                        bus_read(first + sb_addr_t'(4 * i), value);
                        check_data(value, expected_words[i], "RAM fill readback");
                end
        endtask

        task automatic run_cases();
                int fd;
                int fields;
                logic [7:0] kind;
                sb_addr_t addr;
                sb_data_t data;
                sb_data_t value;
                int period;
                int expected;
                int new_duty;
                string line;
                fd = $fopen("bench/pwm_subsystem_cases.txt", "r");
                if (fd == 0) begin
                        report_failure("could not open the case file");
                end
                while ($fscanf(fd, " %c", kind) == 1) begin
                        case (kind)
                                "#": fields = $fgets(line, fd);
                                "W": begin
                                        fields = $fscanf(fd, "%h %h", addr, data);
                                        require_fields(fields, 2);
                                        bus_write(addr, data);
                                end
                                "R": begin
                                        fields = $fscanf(fd, "%h %h", addr, data);
                                        require_fields(fields, 2);
                                        bus_read(addr, value);
                                        check_data(value, data, $sformatf("read of %h", addr));
                                end
                                "P": begin
                                        fields = $fscanf(fd, "%d %d", period, expected);
                                        require_fields(fields, 2);
                                        measure_period(period, expected, 1'b0, '0);
                                end
                                "C": begin
                                        fields = $fscanf(fd, "%d %d %d", period, expected,
                                                new_duty);
                                        require_fields(fields, 3);
                                        measure_period(period, expected, 1'b1, new_duty);
                                end
                                "F": begin
                                        fields = $fscanf(fd, "%h %d", addr, period);
                                        require_fields(fields, 2);
                                        fill_ram(addr, period);
                                end
                                default: report_failure("unknown line kind in the case file");
                        endcase
                end
                $fclose(fd);
        endtask

        initial begin
                pwm_count_t highs;
                void'($urandom(32'h700b));
                rst = 1'b1;
                address = '0;
                write_strobe = 1'b0;
                read_strobe = 1'b0;
                write_data = '0;
                repeat (3) @(posedge clock);
                rst <= 1'b0;
                wait_ready();
                // Output must stay quiet until the PWM is configured
                highs = 0;
                repeat (16) begin
                        @(negedge clock);
                        if (pwm_out !== 1'b0) begin
                                highs++;
                        end
                end
                check_high_count(highs, 0, "pwm_out high cycles after reset");
                run_cases();
                $display("test passed");
                $finish;
        end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+src
src/bus_pkg.sv
src/pwm_pkg.sv
src/sb_interconnect.sv
src/sb_ram.sv
src/pwm_regs.sv
src/pwm_core.sv
src/pwm_subsystem.sv
bench/pwm_subsystem_tb.sv

// ==== bench/pwm_subsystem_cases.txt ====
# W addr data | R addr expected (hex) | F first_addr words (hex, dec)
# P period expected_high | C period expected_high new_duty (dec)
# RAM write and readback at both ends of the window
W 00000000 deadbeef
R 00000000 deadbeef
W 000000fc 12345678
R 000000fc 12345678
W 00000040 a5a55a5a
R 00000040 a5a55a5a
R 00000000 deadbeef
# Random fill of the whole RAM
F 00000000 64
# PWM registers read back as written
W 00001004 0000000a
R 00001004 0000000a
W 00001008 00000003
R 00001008 00000003
W 00001004 ffff1234
R 00001004 00001234
W 00001004 0000000a
# Unknown offset and unmapped addresses
W 0000100c 00000077
R 0000100c 00000000
W 00000800 11111111
R 00000800 00000000
R 00000100 00000000
R 00001010 00000000
R 00002000 00000000
# Enable with period 10 and duty 3
W 00001000 00000001
R 00001000 00000001
P 10 3
P 10 3
# Duty change lands mid-period, applies at the wrap
C 10 3 7
P 10 7
# Disable, then duty above period clips
W 00001000 00000000
P 10 0
W 00001004 00000008
W 00001008 00000014
W 00001000 00000001
P 8 8
W 00001008 00000000
P 8 0
W 00001000 00000000
R 00001000 00000000
P 8 0
